// File: src.f
+incdir+src
src/queue_pkg.sv
src/page_allocator.sv
src/queue_pointer_table.sv
src/queue_memory.sv
src/packet_queue_top.sv
dv/packet_queue_tb.sv

// File: dv/packet_queue_tb.sv
/* Random packet traffic against a queue model. Stored words are capped at 16 so that
   partly filled pages and late frees can never exhaust the 16 pages */
`timescale 1ns/1ps
`include "queue_macros.svh"

module packet_queue_tb
    import queue_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int RUN_CYCLES      = 600;
    localparam int DRAIN_CYCLES    = 64;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RUN_CYCLES + DRAIN_CYCLES + 128;
    localparam int MAX_STORED      = 16;
    localparam int MIN_WORDS       = 200;
    localparam int RING            = 32;

    typedef struct packed {
        logic                        valid;
        logic [`QM_DATA_BYTES*8-1:0] data;
        logic [3:0]                  bytes;
        logic                        last;
        logic [`QM_QUEUE_W-1:0]      queue;
    } expect_t;

    typedef struct packed {
        logic                   valid;
        logic [`QM_QUEUE_W-1:0] queue;
        logic [3:0]             words;
    } commit_t;

    logic                   packet_in;
    logic                   reset;
    packet_word_t           word_in;
    logic                   dequeue_req;
    logic [`QM_QUEUE_W-1:0] dequeue_queue;
    queue_word_t            word_out;
    dequeue_note_t          dequeue_note;

    // Model: one ring per queue, committed words first, then the packet in progress
    expect_t                model [`QM_NUM_QUEUES][RING];
    int                     rd_idx [`QM_NUM_QUEUES];
    int                     wr_idx [`QM_NUM_QUEUES];
    int                     avail [`QM_NUM_QUEUES];
    expect_t                pipe [2];
    commit_t                stage [2];
    int                     stored;
    int                     words_seen;
    int                     pkt_left;
    int                     pkt_len;
    logic [`QM_QUEUE_W-1:0] pkt_queue;
    logic [15:0]            lfsr_state;

    packet_queue_top i_dut (
        .packet_in     (packet_in),
        .reset         (reset),
        .word_in       (word_in),
        .dequeue_req   (dequeue_req),
        .dequeue_queue (dequeue_queue),
        .word_out      (word_out),
        .dequeue_note  (dequeue_note)
    );

    always #(CLK_PERIOD / 2) packet_in = ~packet_in;

    ////////////////////////////////////////////////////////////
    // Helpers

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v          = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic logic [`QM_DATA_BYTES-1:0] keep_from_bytes(input logic [3:0] bytes);
        logic [`QM_DATA_BYTES-1:0] k;
        for (int i = 0; i < `QM_DATA_BYTES; i++) begin
            k[i] = i < bytes;
        end
        return k;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Output of the request made two falling edges ago
    task automatic check_output();
        check_value("word_valid", pipe[1].valid, word_out.valid);
        check_value("note_valid", pipe[1].valid, dequeue_note.valid);
        if (pipe[1].valid) begin
            words_seen++;
            check_value("data_order", pipe[1].data, word_out.data);
            check_value("last_flag", pipe[1].last, word_out.last);
            check_value("keep_roundtrip", keep_from_bytes(pipe[1].bytes), word_out.keep);
            check_value("note_bytes", pipe[1].bytes, dequeue_note.bytes);
            check_value("note_last", pipe[1].last, dequeue_note.last);
            check_value("note_queue", pipe[1].queue, dequeue_note.queue);
            check_value("egress_port", pipe[1].queue / `QM_QUEUES_PER_PORT, word_out.port);
        end
    endtask

    task automatic drive_enqueue(input logic draining);
        expect_t w;
        if (pkt_left == 0 && !draining && random_bits(1) == 1) begin
            pkt_len = int'(random_bits(3) % 7) + 1;
            if (stored + pkt_len <= MAX_STORED) begin
                pkt_left  = pkt_len;
                pkt_queue = random_bits(2);
            end
        end
        // Idle gaps inside a packet keep the queue id steady
        if (pkt_left > 0 && random_bits(2) != 0) begin
            w.valid = 1'b1;
            w.data  = random_bits(64);
            w.last  = pkt_left == 1;
            w.bytes = w.last ? 4'(random_bits(3)) + 4'd1 : 4'(`QM_DATA_BYTES);
            w.queue = pkt_queue;
            word_in.valid = 1'b1;
            word_in.data  = w.data;
            word_in.keep  = keep_from_bytes(w.bytes);
            word_in.last  = w.last;
            word_in.queue = pkt_queue;
            model[pkt_queue][wr_idx[pkt_queue] % RING] = w;
            wr_idx[pkt_queue]++;
            stored++;
            pkt_left--;
            if (w.last) begin
                stage[0].valid = 1'b1;
                stage[0].queue = pkt_queue;
                stage[0].words = 4'(pkt_len);
            end
        end
    endtask

    task automatic drive_dequeue();
        int q;
        int first;
        q = -1;
        if (random_bits(2) != 0) begin
            first = int'(random_bits(2));
            for (int i = 0; i < `QM_NUM_QUEUES; i++) begin
                if (q < 0 && avail[(first + i) % `QM_NUM_QUEUES] > 0) begin
                    q = (first + i) % `QM_NUM_QUEUES;
                end
            end
        end
        if (q >= 0) begin
            dequeue_req   = 1'b1;
            dequeue_queue = q;
            pipe[0]       = model[q][rd_idx[q] % RING];
            rd_idx[q]++;
            avail[q]--;
            stored--;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and checks

    initial begin
        lfsr_state    = 16'd213;
        packet_in     = 1'b0;
        reset         = 1'b1;
        word_in       = '0;
        dequeue_req   = 1'b0;
        dequeue_queue = '0;
        pipe[0]       = '0;
        pipe[1]       = '0;
        stage[0]      = '0;
        stage[1]      = '0;
        stored        = 0;
        words_seen    = 0;
        pkt_left      = 0;
        pkt_len       = 0;
        pkt_queue     = '0;
        for (int q = 0; q < `QM_NUM_QUEUES; q++) begin
            rd_idx[q] = 0;
            wr_idx[q] = 0;
            avail[q]  = 0;
        end
        repeat (RESET_CYCLES) @(negedge packet_in);
        reset = 1'b0;

        for (int cycle = 0; cycle < RUN_CYCLES + DRAIN_CYCLES; cycle++) begin
            @(negedge packet_in);
            check_output();
            pipe[1] = pipe[0];
            pipe[0] = '0;
            // A packet becomes readable two edges after its last word
            if (stage[1].valid) begin
                avail[stage[1].queue] += int'(stage[1].words);
            end
            stage[1] = stage[0];
            stage[0] = '0;
            word_in.valid = 1'b0;
            dequeue_req   = 1'b0;
            drive_enqueue(cycle >= RUN_CYCLES);
            drive_dequeue();
        end

        // Outputs of the last requests still in flight
        word_in.valid = 1'b0;
        dequeue_req   = 1'b0;
        repeat (2) begin
            @(negedge packet_in);
            check_output();
            pipe[1] = pipe[0];
            pipe[0] = '0;
        end

        assert (stored == 0 && pkt_left == 0) else begin
            $display("The model still holds %0d words after the drain phase", stored);
            $display("Something failed");
            $fatal(1);
        end
        assert (words_seen > MIN_WORDS) else begin
            $display("Only %0d words passed through the buffer", words_seen);
            $display("Something failed");
            $fatal(1);
        end
        $display("Everything OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test reached its end");
        $display("Something failed");
        $fatal(1);
    end

endmodule

// File: src/packet_queue_top.sv
/* Paged packet queue buffer. Always ready, no back-pressure; dequeue output follows the
   request by two cycles and requests to an empty queue produce nothing */
`timescale 1ns/1ps
`include "queue_macros.svh"

module packet_queue_top
    import queue_pkg::*;
(
    input  logic                   packet_in,
    input  logic                   reset,
    input  packet_word_t           word_in,
    input  logic                   dequeue_req,
    input  logic [`QM_QUEUE_W-1:0] dequeue_queue,
    output queue_word_t            word_out,
    output dequeue_note_t          dequeue_note
);

    enqueue_meta_t         enqueue_meta;
    head_pointer_t         head;
    page_link_t            link;
    enqueue_commit_t       commit;
    page_free_t            page_free;
    logic                  alloc;
    logic [`QM_PAGE_W-1:0] alloc_page;

    page_allocator i_page_allocator (
        .packet_in  (packet_in),
        .reset      (reset),
        .alloc      (alloc),
        .free       (page_free),
        .alloc_page (alloc_page)
    );

    queue_pointer_table i_queue_pointer_table (
        .packet_in     (packet_in),
        .reset         (reset),
        .in_queue      (word_in.queue),
        .dequeue_req   (dequeue_req),
        .dequeue_queue (dequeue_queue),
        .link          (link),
        .commit        (commit),
        .alloc_page    (alloc_page),
        .enqueue_meta  (enqueue_meta),
        .head          (head),
        .alloc         (alloc)
    );

    queue_memory i_queue_memory (
        .packet_in    (packet_in),
        .reset        (reset),
        .word_in      (word_in),
        .enqueue_meta (enqueue_meta),
        .head         (head),
        .link         (link),
        .commit       (commit),
        .word_out     (word_out),
        .dequeue_note (dequeue_note),
        .page_free    (page_free)
    );

endmodule

// File: src/queue_memory.sv
/* Paged word store. Keep must be a run of ones from byte 0, and only the last word of a
   packet may be partial. Dequeue data follows the head pointer by one cycle */
`timescale 1ns/1ps
`include "queue_macros.svh"

module queue_memory
    import queue_pkg::*;
(
    input  logic            packet_in,
    input  logic            reset,
    input  packet_word_t    word_in,
    input  enqueue_meta_t   enqueue_meta,
    input  head_pointer_t   head,
    output page_link_t      link,
    output enqueue_commit_t commit,
    output queue_word_t     word_out,
    output dequeue_note_t   dequeue_note,
    output page_free_t      page_free
);

    localparam int ADDR_W = `QM_PAGE_W + `QM_OFFSET_W;
    localparam int DEPTH  = `QM_NUM_PAGES * `QM_WORDS_PER_PAGE;
    localparam logic [`QM_OFFSET_W-1:0] LAST_OFF = `QM_OFFSET_W'(`QM_WORDS_PER_PAGE - 1);

    // Valid byte count, full word stored as zero
    function automatic logic [`QM_KEEP_CODE_W-1:0] encode_keep(
        input logic [`QM_DATA_BYTES-1:0] keep
    );
        for (int i = 1; i < `QM_DATA_BYTES; i++) begin
            if (!keep[i]) begin
                return `QM_KEEP_CODE_W'(i);
            end
        end
        return '0;
    endfunction

    function automatic logic [`QM_DATA_BYTES-1:0] decode_keep(
        input logic [`QM_KEEP_CODE_W-1:0] code
    );
        if (code == '0) begin
            return '1;
        end
        return `QM_DATA_BYTES'((1 << code) - 1);
    endfunction

    logic [`QM_DATA_BYTES*8-1:0] data_mem [DEPTH];
    logic [`QM_KEEP_CODE_W:0]    tag_mem  [DEPTH];

    // Enqueue walk
    logic                        sop;
    logic [`QM_PAGE_W-1:0]       cur_page;
    logic [`QM_OFFSET_W-1:0]     tail_off;
    logic [`QM_PAGE_W-1:0]       next_page;
    logic [`QM_OFFSET_W:0]       pkt_words;
    logic [`QM_PAGE_W-1:0]       wr_page;
    logic [`QM_OFFSET_W-1:0]     wr_off;
    logic [`QM_PAGE_W-1:0]       wr_reserve;
    logic [`QM_PAGE_W-1:0]       after_page;
    logic                        page_end;
    logic [`QM_OFFSET_W:0]       words_now;

    // Write stage
    logic                        wren;
    logic [ADDR_W-1:0]           wr_addr;
    logic [`QM_DATA_BYTES*8-1:0] wr_data;
    logic [`QM_KEEP_CODE_W:0]    wr_tag;

    // Read stage
    logic                        rd_valid;
    logic [`QM_DATA_BYTES*8-1:0] rd_data;
    logic [`QM_KEEP_CODE_W-1:0]  rd_code;
    logic                        rd_last;
    logic [`QM_QUEUE_W-1:0]      rd_queue;

    ////////////////////////////////////////////////////////////
    // Enqueue

    // First word takes the queue's pointers, later words follow the walk
    assign wr_page    = sop ? enqueue_meta.page : cur_page;
    assign wr_off     = sop ? enqueue_meta.offset : tail_off;
    assign wr_reserve = sop ? enqueue_meta.reserve : next_page;
    assign page_end   = wr_off == LAST_OFF;
    assign after_page = page_end ? wr_reserve : wr_page;
    assign words_now  = sop ? (`QM_OFFSET_W+1)'(1) : pkt_words + 1'b1;

    always_ff @(posedge packet_in) begin
        if (reset) begin
            sop          <= 1'b1;
            wren         <= 1'b0;
            link.valid   <= 1'b0;
            commit.valid <= 1'b0;
        end else begin
            wren         <= word_in.valid;
            link.valid   <= word_in.valid && page_end;
            commit.valid <= word_in.valid && word_in.last;
            if (word_in.valid) begin
                sop <= word_in.last;
            end
        end
        // Stage 0
        wr_data <= word_in.data;
        wr_tag  <= {encode_keep(word_in.keep), word_in.last};
        if (word_in.valid) begin
            wr_addr       <= {wr_page, wr_off};
            cur_page      <= after_page;
            tail_off      <= wr_off + 1'b1;
            // Fresh reserve arrives a cycle after a page crossing
            next_page     <= enqueue_meta.reserve;
            pkt_words     <= words_now;
            link.filled   <= wr_page;
            link.new_page <= wr_reserve;
            commit.page   <= after_page;
            commit.offset <= wr_off + 1'b1;
            commit.words  <= words_now;
        end
        // Stage 1
        if (wren) begin
            data_mem[wr_addr] <= wr_data;
            tag_mem[wr_addr]  <= wr_tag;
        end
    end

    ////////////////////////////////////////////////////////////
    // Dequeue

    always_ff @(posedge packet_in) begin
        if (reset) begin
            rd_valid        <= 1'b0;
            page_free.valid <= 1'b0;
        end else begin
            rd_valid        <= head.valid;
            page_free.valid <= head.valid && head.offset == LAST_OFF;
        end
        if (head.valid) begin
            rd_data           <= data_mem[{head.page, head.offset}];
            {rd_code, rd_last} <= tag_mem[{head.page, head.offset}];
            rd_queue          <= head.queue;
            page_free.page    <= head.page;
        end
    end

    assign word_out.valid = rd_valid;
    assign word_out.data  = rd_data;
    assign word_out.keep  = decode_keep(rd_code);
    assign word_out.last  = rd_last;
    assign word_out.port  = PORT_W'(rd_queue / `QM_QUEUES_PER_PORT);

    assign dequeue_note.valid = rd_valid;
    assign dequeue_note.bytes = (rd_code == '0) ?
                                (`QM_KEEP_CODE_W+1)'(`QM_DATA_BYTES) : {1'b0, rd_code};
    assign dequeue_note.last  = rd_last;
    assign dequeue_note.queue = rd_queue;

    ////////////////////////////////////////////////////////////
    // Checks

    // The keep code only holds a contiguous run, and only a last word may be short
    assert property (@(posedge packet_in) disable iff (reset)
        word_in.valid |-> word_in.keep != '0
                          && (word_in.keep & (word_in.keep + 1'b1)) == '0
                          && (word_in.last || word_in.keep == '1));

endmodule

// File: src/queue_pointer_table.sv
/* Per-queue pointers and page chain. Words of one packet must arrive together on one queue,
   and a packet only becomes visible to dequeue once its commit has landed */
`timescale 1ns/1ps
`include "queue_macros.svh"

module queue_pointer_table
    import queue_pkg::*;
(
    input  logic                   packet_in,
    input  logic                   reset,
    input  logic [`QM_QUEUE_W-1:0] in_queue,
    input  logic                   dequeue_req,
    input  logic [`QM_QUEUE_W-1:0] dequeue_queue,
    input  page_link_t             link,
    input  enqueue_commit_t        commit,
    input  logic [`QM_PAGE_W-1:0]  alloc_page,
    output enqueue_meta_t          enqueue_meta,
    output head_pointer_t          head,
    output logic                   alloc
);

    localparam int CNT_W = $clog2(`QM_NUM_PAGES * `QM_WORDS_PER_PAGE + 1);
    localparam logic [`QM_OFFSET_W-1:0] LAST_OFF = `QM_OFFSET_W'(`QM_WORDS_PER_PAGE - 1);

    // Per-queue state
    logic [`QM_PAGE_W-1:0]   head_page [`QM_NUM_QUEUES];
    logic [`QM_OFFSET_W-1:0] head_off  [`QM_NUM_QUEUES];
    logic [`QM_PAGE_W-1:0]   cur_page  [`QM_NUM_QUEUES];
    logic [`QM_OFFSET_W-1:0] tail_off  [`QM_NUM_QUEUES];
    logic [`QM_PAGE_W-1:0]   reserve   [`QM_NUM_QUEUES];
    logic [CNT_W-1:0]        count     [`QM_NUM_QUEUES];

    // Successor of each page in its queue's chain
    logic [`QM_PAGE_W-1:0]   next_of [`QM_NUM_PAGES];

    // Queue of the word now one stage into queue_memory
    logic [`QM_QUEUE_W-1:0]  enq_queue;
    logic                    same_queue;
    logic                    deq_ok;

    assign alloc      = link.valid;
    assign same_queue = in_queue == enq_queue;
    assign deq_ok     = dequeue_req && count[dequeue_queue] != '0;

    ////////////////////////////////////////////////////////////
    // Enqueue metadata

    // Forward strobes still in flight so back-to-back packets see fresh pointers
    always_comb begin
        enqueue_meta.page    = cur_page[in_queue];
        enqueue_meta.offset  = tail_off[in_queue];
        enqueue_meta.reserve = reserve[in_queue];
        if (same_queue && commit.valid) begin
            enqueue_meta.page   = commit.page;
            enqueue_meta.offset = commit.offset;
        end
        if (same_queue && link.valid) begin
            enqueue_meta.page    = link.new_page;
            enqueue_meta.reserve = alloc_page;
        end
    end

    always_ff @(posedge packet_in) begin
        if (link.valid) begin
            next_of[link.filled] <= link.new_page;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointer state and head reads

    always_ff @(posedge packet_in) begin
        if (reset) begin
            enq_queue  <= '0;
            head.valid <= 1'b0;
            for (int q = 0; q < `QM_NUM_QUEUES; q++) begin
                head_page[q] <= `QM_PAGE_W'(2 * q);
                head_off[q]  <= '0;
                cur_page[q]  <= `QM_PAGE_W'(2 * q);
                tail_off[q]  <= '0;
                reserve[q]   <= `QM_PAGE_W'(2 * q + 1);
                count[q]     <= '0;
            end
        end else begin
            enq_queue  <= in_queue;
            head.valid <= deq_ok;
            if (link.valid) begin
                cur_page[enq_queue] <= link.new_page;
                reserve[enq_queue]  <= alloc_page;
            end
            if (commit.valid) begin
                tail_off[enq_queue] <= commit.offset;
            end
            // Walk the head, following the chain at a page end
            if (deq_ok) begin
                head_off[dequeue_queue] <= head_off[dequeue_queue] + 1'b1;
                if (head_off[dequeue_queue] == LAST_OFF) begin
                    head_page[dequeue_queue] <= next_of[head_page[dequeue_queue]];
                end
            end
            for (int q = 0; q < `QM_NUM_QUEUES; q++) begin
                count[q] <= count[q]
                    + ((commit.valid && enq_queue == `QM_QUEUE_W'(q)) ?
                       CNT_W'(commit.words) : '0)
                    - CNT_W'(deq_ok && dequeue_queue == `QM_QUEUE_W'(q));
            end
        end
        head.page   <= head_page[dequeue_queue];
        head.offset <= head_off[dequeue_queue];
        head.queue  <= dequeue_queue;
    end

    ////////////////////////////////////////////////////////////
    // Checks

    // A link must extend the chain from the queue's own current page
    assert property (@(posedge packet_in) disable iff (reset)
        link.valid |-> link.filled == cur_page[enq_queue]);

    // The committed tail must sit on the page the chain ends in
    assert property (@(posedge packet_in) disable iff (reset)
        commit.valid |-> commit.page
                         == (link.valid ? link.new_page : cur_page[enq_queue]));

endmodule

// File: src/page_allocator.sv
/* Free page FIFO, preloaded at reset with the pages no queue owns.
   A pop and a push may share a cycle; alloc_page is valid whenever the list is nonempty */
`timescale 1ns/1ps
`include "queue_macros.svh"

module page_allocator
    import queue_pkg::*;
(
    input  logic                  packet_in,
    input  logic                  reset,
    input  logic                  alloc,
    input  page_free_t            free,
    output logic [`QM_PAGE_W-1:0] alloc_page
);

    // Each queue starts with a head page and a reserve page
    localparam int OWNED   = 2 * `QM_NUM_QUEUES;
    localparam int PRELOAD = `QM_NUM_PAGES - OWNED;

    logic [`QM_PAGE_W-1:0] fifo [`QM_NUM_PAGES];
    logic [`QM_PAGE_W-1:0] rd_ptr;
    logic [`QM_PAGE_W-1:0] wr_ptr;
    logic [`QM_PAGE_W:0]   level;

    assign alloc_page = fifo[rd_ptr];

    always_ff @(posedge packet_in) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= `QM_PAGE_W'(PRELOAD);
            level  <= (`QM_PAGE_W+1)'(PRELOAD);
            for (int i = 0; i < PRELOAD; i++) begin
                fifo[i] <= `QM_PAGE_W'(OWNED + i);
            end
        end else begin
            if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (free.valid) begin
                fifo[wr_ptr] <= free.page;
                wr_ptr       <= wr_ptr + 1'b1;
            end
            // Occupancy
            case ({alloc, free.valid})
                2'b10:   level <= level - 1'b1;
                2'b01:   level <= level + 1'b1;
                default: level <= level;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    // Enqueue must never outrun the pages released by dequeue
    assert property (@(posedge packet_in) disable iff (reset)
        alloc |-> level != '0);

    // A page freed twice would overfill the list
    assert property (@(posedge packet_in) disable iff (reset)
        free.valid && !alloc |-> level != (`QM_PAGE_W+1)'(`QM_NUM_PAGES));

endmodule

// File: src/queue_pkg.sv
/* Shared bus structs. The commit word count limits a packet to 7 words */
`include "queue_macros.svh"

package queue_pkg;

    // Egress port field width
    localparam int PORT_W = `QM_QUEUE_W - $clog2(`QM_QUEUES_PER_PORT);

    typedef struct packed {
        logic                        valid;
        logic [`QM_DATA_BYTES*8-1:0] data;
        logic [`QM_DATA_BYTES-1:0]   keep;
        logic                        last;
        logic [`QM_QUEUE_W-1:0]      queue;
    } packet_word_t;

    typedef struct packed {
        logic [`QM_PAGE_W-1:0]   page;
        logic [`QM_OFFSET_W-1:0] offset;
        logic [`QM_PAGE_W-1:0]   reserve;
    } enqueue_meta_t;

    typedef struct packed {
        logic                    valid;
        logic [`QM_PAGE_W-1:0]   page;
        logic [`QM_OFFSET_W-1:0] offset;
        logic [`QM_QUEUE_W-1:0]  queue;
    } head_pointer_t;

    typedef struct packed {
        logic                  valid;
        logic [`QM_PAGE_W-1:0] filled;
        logic [`QM_PAGE_W-1:0] new_page;
    } page_link_t;

    // Tail is the slot after the last word written
    typedef struct packed {
        logic                    valid;
        logic [`QM_PAGE_W-1:0]   page;
        logic [`QM_OFFSET_W-1:0] offset;
        logic [`QM_OFFSET_W:0]   words;
    } enqueue_commit_t;

    typedef struct packed {
        logic                        valid;
        logic [`QM_DATA_BYTES*8-1:0] data;
        logic [`QM_DATA_BYTES-1:0]   keep;
        logic                        last;
        logic [PORT_W-1:0]           port;
    } queue_word_t;

    typedef struct packed {
        logic                      valid;
        logic [`QM_KEEP_CODE_W:0]  bytes;
        logic                      last;
        logic [`QM_QUEUE_W-1:0]    queue;
    } dequeue_note_t;

    typedef struct packed {
        logic                  valid;
        logic [`QM_PAGE_W-1:0] page;
    } page_free_t;

endpackage

// File: src/queue_macros.svh
/* Buffer geometry. The derived widths are not computed and must be kept in step by hand */
`ifndef QUEUE_MACROS_SVH
`define QUEUE_MACROS_SVH

// Word and page geometry
`define QM_DATA_BYTES      8
`define QM_WORDS_PER_PAGE  4
`define QM_NUM_PAGES       16

// Queue arrangement
`define QM_NUM_QUEUES      4
`define QM_QUEUES_PER_PORT 2

// Derived widths
`define QM_PAGE_W          4
`define QM_OFFSET_W        2
`define QM_QUEUE_W         2
`define QM_KEEP_CODE_W     3

`endif
